// File: Makefile
VERILATOR  ?= verilator
TOP        := copTb
RTL_TOP    := copTop
FILELIST   := list.f
OBJ_DIR    := obj_dir
SIM_FLAGS  := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert
PASS_MSG   := Test completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Fails unless the simulation printed the pass message
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: dv/copTb.sv
module copTb
  import copPkg::*;
();

  localparam int          COP_NUM      = 2;
  localparam int          CLK_PERIOD   = 8;
  localparam int          RESET_CYCLES = 10;
  localparam logic [31:0] SEED         = 32'h0118_707f;

  localparam logic [5:0] MY_COP    = COP0 | 6'(COP_NUM);
  localparam logic [5:0] MY_LWC    = LWC | 6'(COP_NUM);
  localparam logic [5:0] MY_SWC    = SWC | 6'(COP_NUM);
  localparam logic [5:0] OTHER_COP = COP1;
  localparam logic [5:0] OTHER_LWC = LWC | 6'd1;
  localparam wordT       NOP_WORD  = 32'h0000_0000;
  localparam wordT       NON_COP   = 32'h0085_1021;   // An ordinary ALU instruction

  localparam haltT NO_HALT   = 4'b0000;
  localparam haltT PIPE_HALT = 4'b1000;
  localparam haltT DC_HALT_M = 4'b0100;
  localparam haltT DC_HALT_W = 4'b0010;
  localparam haltT DW_HALT_W = 4'b0001;

  localparam copOpT IDLE_OP = '{op: opNone, addr: '0};

  typedef struct packed {
    wordT    inst;
    copOpE   kind;   // Meaning of inst for this coprocessor number
    regAddrT addr;
    logic    stall;
    logic    exc;
    haltT    halt;
    wordT    upIn;
    wordT    downIn;
    wordT    expUp;
    wordT    expDown;
    logic    expCondN;
  } stepT;

  logic SYSCLK;
  logic rst;
  wordT instIf;
  logic iStallIf;
  logic exception;
  haltT halt;
  wordT dbusUpIn;
  wordT dbusUpOut;
  wordT dbusDownIn;
  wordT dbusDownOut;
  logic cpCondN;

  stepT  steps[$];
  string names[$];
  int    errors;
  int    checks;
  bit    tableReady;

  // Reference pipeline and register banks
  copOpT mE;
  copOpT mM;
  copOpT mW;
  wordT  mRead;
  wordT  mWrData;
  wordT  mGen [32];
  wordT  mCon [32];
  logic  mCondN;

  copTop #(
    .COP_NUM(COP_NUM)
  ) DUT (
    .SYSCLK     (SYSCLK),
    .rst        (rst),
    .instIf     (instIf),
    .iStallIf   (iStallIf),
    .exception  (exception),
    .halt       (halt),
    .dbusUpIn   (dbusUpIn),
    .dbusUpOut  (dbusUpOut),
    .dbusDownIn (dbusDownIn),
    .dbusDownOut(dbusDownOut),
    .cpCondN    (cpCondN)
  );

  initial begin
    SYSCLK = 1'b0;
    forever #(CLK_PERIOD / 2) SYSCLK = ~SYSCLK;
  end

  //////////////////////////////
  // Table construction
  //////////////////////////////

  function automatic wordT moveWord(input logic [5:0] opc, input logic [4:0] rs,
                                    input regAddrT rd);
    return {opc, rs, 5'd3, rd, 11'd0};
  endfunction

  function automatic wordT memWord(input logic [5:0] opc, input regAddrT rt);
    return {opc, 5'd29, rt, 16'h0040};   // Base register and offset are don't care
  endfunction

  task automatic addStep(input string name, input wordT inst, input copOpE kind,
                         input regAddrT addr, input logic exc, input haltT hlt,
                         input logic stall);
    stepT s;
    s        = '0;
    s.inst   = inst;
    s.kind   = kind;
    s.addr   = addr;
    s.exc    = exc;
    s.halt   = hlt;
    s.stall  = stall;
    s.upIn   = $urandom();
    s.downIn = $urandom();
    steps.push_back(s);
    names.push_back(name);
  endtask

  task automatic addOp(input string name, input wordT inst, input copOpE kind,
                       input regAddrT addr);
    addStep(name, inst, kind, addr, 1'b0, NO_HALT, 1'b0);
  endtask

  task automatic addIdle(input int count);
    for (int i = 0; i < count; i++) begin
      addStep("idle", NOP_WORD, opNone, 5'd0, 1'b0, NO_HALT, 1'b0);
    end
  endtask

  task automatic setDownBus(input int idx, input wordT value);
    stepT s;
    s        = steps[idx];
    s.downIn = value;
    steps[idx] = s;
  endtask

  task automatic buildTable();
    int condIdx;
    addOp("mtcGen5", moveWord(MY_COP, MT, 5'd5), opMtc, 5'd5);
    addIdle(2);
    addOp("mfcGen5", moveWord(MY_COP, MF, 5'd5), opMfc, 5'd5);
    addIdle(2);
    addOp("ctcCon7", moveWord(MY_COP, CT, 5'd7), opCtc, 5'd7);
    addIdle(2);
    addOp("cfcCon7", moveWord(MY_COP, CF, 5'd7), opCfc, 5'd7);
    addOp("mfcGen7", moveWord(MY_COP, MF, 5'd7), opMfc, 5'd7);   // Must still read zero
    addIdle(2);
    addOp("lwcGen9", memWord(MY_LWC, 5'd9), opLwc, 5'd9);
    addIdle(2);
    addOp("swcGen9", memWord(MY_SWC, 5'd9), opSwc, 5'd9);
    addIdle(2);
    addOp("nonCop", NON_COP, opNone, 5'd0);
    addOp("bcCond", moveWord(MY_COP, BC, 5'd0), opBc, 5'd0);
    addOp("otherCopMf", moveWord(OTHER_COP, MF, 5'd5), opNone, 5'd0);
    addOp("otherCopLwc", memWord(OTHER_LWC, 5'd9), opNone, 5'd0);
    addIdle(2);
    addOp("mfcGen9", moveWord(MY_COP, MF, 5'd9), opMfc, 5'd9);   // Other LWC left it alone
    // CTC sits in W while the cache halts, so an early write shows on cpCondN
    condIdx = steps.size();
    addOp("ctcCon0Held", moveWord(MY_COP, CT, 5'd0), opCtc, 5'd0);
    addIdle(2);
    setDownBus(condIdx + 2, 32'h3C3C_0001);
    addStep("haltDcW", NOP_WORD, opNone, 5'd0, 1'b0, DC_HALT_W, 1'b0);
    addStep("haltDwW", NOP_WORD, opNone, 5'd0, 1'b0, DW_HALT_W, 1'b0);
    addIdle(2);
    addOp("cfcCon0", moveWord(MY_COP, CF, 5'd0), opCfc, 5'd0);
    addStep("haltPipe", NOP_WORD, opNone, 5'd0, 1'b0, PIPE_HALT, 1'b0);
    addIdle(1);
    addStep("haltDcM", NOP_WORD, opNone, 5'd0, 1'b0, DC_HALT_M, 1'b0);
    addStep("haltPipeM", NOP_WORD, opNone, 5'd0, 1'b0, PIPE_HALT, 1'b0);
    addIdle(2);
    addOp("mtcGen5Killed", moveWord(MY_COP, MT, 5'd5), opMtc, 5'd5);
    addIdle(1);
    addStep("exception", NOP_WORD, opNone, 5'd0, 1'b1, NO_HALT, 1'b0);
    addIdle(1);
    addOp("mfcGen5Old", moveWord(MY_COP, MF, 5'd5), opMfc, 5'd5);
    addIdle(2);
    addStep("mtcGen20Stalled", moveWord(MY_COP, MT, 5'd20), opMtc, 5'd20, 1'b0, NO_HALT,
            1'b1);
    addIdle(2);
    addOp("mfcGen20", moveWord(MY_COP, MF, 5'd20), opMfc, 5'd20);
    addIdle(2);
    //////////////////////////////
    condIdx = steps.size();
    addOp("ctcCon0Clear", moveWord(MY_COP, CT, 5'd0), opCtc, 5'd0);
    addIdle(4);
    setDownBus(condIdx + 2, 32'hA5A5_0000);
    condIdx = steps.size();
    addOp("ctcCon0Set", moveWord(MY_COP, CT, 5'd0), opCtc, 5'd0);
    addIdle(4);
    setDownBus(condIdx + 2, 32'h5A5A_0001);   // Value on the down bus in the CTC's M cycle
    addIdle(2);   // Drain so the last rows are checked
  endtask

  //////////////////////////////
  // Expected values
  //////////////////////////////

  // Steps the reference through every row and stores what each row should see two cycles later
  task automatic predict();
    stepT  s;
    stepT  t;
    logic  haltAny;
    logic  cacheHalt;
    logic  drives;
    wordT  copIn;
    copOpT fetched;
    mE      = IDLE_OP;
    mM      = IDLE_OP;
    mW      = IDLE_OP;
    mRead   = '0;
    mWrData = '0;
    mCondN  = 1'b1;
    for (int i = 0; i < 32; i++) begin
      mGen[i] = '0;
      mCon[i] = '0;
    end
    for (int c = 0; c < steps.size(); c++) begin
      s         = steps[c];
      haltAny   = |s.halt;
      cacheHalt = s.halt.dcHaltM | s.halt.dcHaltW | s.halt.dwHaltW;
      drives    = (mM.op inside {opMfc, opCfc, opSwc}) && !haltAny;
      copIn     = ((mM.op == opLwc) || cacheHalt) ? s.upIn : s.downIn;
      if (c >= 2) begin
        t          = steps[c - 2];
        t.expUp    = drives ? mRead : s.upIn;
        t.expDown  = drives ? mRead : s.downIn;
        t.expCondN = mCondN;
        steps[c - 2] = t;
      end
      if (!haltAny) begin
        // Read and condition both see the banks before this edge's write
        case (mE.op)
          opMfc, opSwc: mRead = mGen[mE.addr];
          opCfc:        mRead = mCon[mE.addr];
          default:      ;
        endcase
        mCondN = ~mCon[0][0];
        case (mW.op)
          opMtc, opLwc: mGen[mW.addr] = mWrData;
          opCtc:        mCon[mW.addr] = mWrData;
          default:      ;
        endcase
        if (mM.op inside {opMtc, opCtc, opLwc}) begin
          mWrData = copIn;
        end
      end
      fetched = IDLE_OP;
      if (!s.stall) begin
        fetched.op   = s.kind;
        fetched.addr = s.addr;
      end
      if (s.exc) begin
        if (!haltAny) begin
          mW = IDLE_OP;
        end
        mE = IDLE_OP;
        mM = IDLE_OP;
      end else if (!haltAny) begin
        mW = mM;
        mM = mE;
        mE = fetched;
      end
    end
  endtask

  //////////////////////////////
  // Drive and check
  //////////////////////////////

  task automatic applyRow(input int idx);
    stepT s;
    s          = steps[idx];
    instIf     = s.inst;
    iStallIf   = s.stall;
    exception  = s.exc;
    halt       = s.halt;
    dbusUpIn   = s.upIn;
    dbusDownIn = s.downIn;
  endtask

  task automatic checkRow(input int idx);
    stepT s;
    s      = steps[idx];
    checks = checks + 3;
    assert (dbusUpOut === s.expUp) else begin
      errors++;
      $display("ERROR %s dbusUpOut: expected %h, actual %h", names[idx], s.expUp, dbusUpOut);
    end
    assert (dbusDownOut === s.expDown) else begin
      errors++;
      $display("ERROR %s dbusDownOut: expected %h, actual %h", names[idx], s.expDown,
               dbusDownOut);
    end
    assert (cpCondN === s.expCondN) else begin
      errors++;
      $display("ERROR %s cpCondN: expected %b, actual %b", names[idx], s.expCondN, cpCondN);
    end
  endtask

  initial begin
    errors     = 0;
    checks     = 0;
    tableReady = 1'b0;
    rst        = 1'b1;
    instIf     = '0;
    iStallIf   = 1'b0;
    exception  = 1'b0;
    halt       = NO_HALT;
    dbusUpIn   = '0;
    dbusDownIn = '0;
    void'($urandom(SEED));
    buildTable();
    predict();
    tableReady = 1'b1;
    repeat (RESET_CYCLES) @(posedge SYSCLK);
    for (int c = 0; c < steps.size(); c++) begin
      #1;
      rst = 1'b0;
      applyRow(c);
      #4;   // Mid cycle, well away from both edges
      if (c >= 2) begin
        checkRow(c - 2);
      end
      @(posedge SYSCLK);
    end
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  initial begin
    wait (tableReady);
    #((steps.size() + 20) * CLK_PERIOD);
    $display("Timeout: the stimulus table did not finish in the expected time");
    $display("Test failed");
    $finish;
  end

endmodule

// File: hdl/copBus.sv
module copBus
  import copPkg::*;
#(
  parameter int COP_NUM = 0
) (
  input  logic  SYSCLK,
  input  logic  rst,
  input  wordT  instIf,
  input  logic  iStallIf,
  input  logic  exception,
  input  haltT  halt,
  input  wordT  dbusUpIn,
  output wordT  dbusUpOut,
  input  wordT  dbusDownIn,
  output wordT  dbusDownOut,
  output logic  cpCondN,
  output rdReqT rdReq,
  output wrReqT wrReq,
  input  wordT  rdData,
  input  logic  condN
);

  logic cmemOpM;
  logic cDriverM;
  wordT crdDataM;
  wordT dbusCopIn;

  copIf #(
    .COP_NUM(COP_NUM)
  ) ctrl (
    .SYSCLK   (SYSCLK),
    .rst      (rst),
    .instIf   (instIf),
    .iStallIf (iStallIf),
    .exception(exception),
    .halt     (halt),
    .rdData   (rdData),
    .condN    (condN),
    .dbusCopIn(dbusCopIn),
    .rdReq    (rdReq),
    .wrReq    (wrReq),
    .cmemOpM  (cmemOpM),
    .cDriverM (cDriverM),
    .crdDataM (crdDataM),
    .cpCondN  (cpCondN)
  );

  copBusSteer steer (
    .halt       (halt),
    .cmemOpM    (cmemOpM),
    .cDriverM   (cDriverM),
    .crdDataM   (crdDataM),
    .dbusUpIn   (dbusUpIn),
    .dbusDownIn (dbusDownIn),
    .dbusUpOut  (dbusUpOut),
    .dbusDownOut(dbusDownOut),
    .dbusCopIn  (dbusCopIn)
  );

endmodule

// File: hdl/copBusSteer.sv
module copBusSteer
  import copPkg::*;
(
  input  haltT halt,
  input  logic cmemOpM,
  input  logic cDriverM,
  input  wordT crdDataM,
  input  wordT dbusUpIn,
  input  wordT dbusDownIn,
  output wordT dbusUpOut,
  output wordT dbusDownOut,
  output wordT dbusCopIn
);

  logic cacheHalt;
  logic drive;

  // Cache side stalls in M or W
  assign cacheHalt = halt.dcHaltM | halt.dcHaltW | halt.dwHaltW;

  //////////////////////////////
  // Outgoing buses
  //////////////////////////////

  // Read data replaces both buses only in a clean M cycle
  assign drive = cDriverM & ~cacheHalt & ~halt.pipeHalt;

  always_comb begin
    dbusUpOut   = dbusUpIn;
    dbusDownOut = dbusDownIn;
    if (drive) begin
      dbusUpOut   = crdDataM;
      dbusDownOut = crdDataM;
    end
  end

  //////////////////////////////
  // Incoming data
  //////////////////////////////

  assign dbusCopIn = (cmemOpM | cacheHalt) ? dbusUpIn : dbusDownIn;   // Loads come up from cache

  // A coprocessor store never coincides with a coprocessor load in M
  always_comb begin
    noDriveOnLoad: assert final (!(cDriverM && cmemOpM));
  end

endmodule

// File: hdl/copDecode.sv
module copDecode
  import copPkg::*;
#(
  parameter int COP_NUM = 0
) (
  input  wordT  inst,
  output copOpT op
);

  // Opcodes this coprocessor answers to
  localparam logic [5:0] COP_OPC = COP0 | 6'(COP_NUM);
  localparam logic [5:0] LWC_OPC = LWC | 6'(COP_NUM);
  localparam logic [5:0] SWC_OPC = SWC | 6'(COP_NUM);

  instFieldsT f;

  assign f = instFieldsT'(inst);

  always_comb begin
    op.op   = opNone;
    op.addr = '0;
    if (f.opcode == COP_OPC) begin
      op.addr = f.rd;   // Moves name the coprocessor register in rd
      case (f.rs)
        MF: begin
          op.op = opMfc;
        end
        CF: begin
          op.op = opCfc;
        end
        MT: begin
          op.op = opMtc;
        end
        CT: begin
          op.op = opCtc;
        end
        BC: begin
          op.op   = opBc;
          op.addr = '0;   // Branch only samples the condition
        end
        default: begin
          op.addr = '0;
        end
      endcase
    end else if (f.opcode == LWC_OPC) begin
      op.op   = opLwc;
      op.addr = f.rt;
    end else if (f.opcode == SWC_OPC) begin
      op.op   = opSwc;
      op.addr = f.rt;
    end
  end

endmodule

// File: hdl/copIf.sv
module copIf
  import copPkg::*;
#(
  parameter int COP_NUM = 0
) (
  input  logic  SYSCLK,
  input  logic  rst,
  input  wordT  instIf,
  input  logic  iStallIf,
  input  logic  exception,
  input  haltT  halt,
  input  wordT  rdData,
  input  logic  condN,
  input  wordT  dbusCopIn,
  output rdReqT rdReq,
  output wrReqT wrReq,
  output logic  cmemOpM,
  output logic  cDriverM,
  output wordT  crdDataM,
  output logic  cpCondN
);

  localparam copOpT NOP_OP = '{op: opNone, addr: '0};

  copOpT decIf;
  copOpT opE;
  copOpT opM;
  copOpT opW;
  logic  advance;
  logic  wrM;
  wordT  wrDataW;

  copDecode #(
    .COP_NUM(COP_NUM)
  ) decode (
    .inst(instIf),
    .op  (decIf)
  );

  assign advance = ~|halt;   // Any halt bit freezes every stage

  //////////////////////////////
  // Stage registers
  //////////////////////////////

  always_ff @(posedge SYSCLK) begin
    if (rst) begin
      opE <= NOP_OP;
      opM <= NOP_OP;
      opW <= NOP_OP;
    end else if (exception) begin
      opE <= NOP_OP;
      opM <= NOP_OP;
      if (advance) begin
        opW <= NOP_OP;   // The killed M instruction never reaches W
      end
    end else if (advance) begin
      opE <= iStallIf ? NOP_OP : decIf;
      opM <= opE;
      opW <= opM;
    end
  end

  //////////////////////////////
  // E stage read
  //////////////////////////////

  always_comb begin
    rdReq      = '0;
    rdReq.addr = opE.addr;
    if (advance) begin
      rdReq.gen = (opE.op == opMfc) || (opE.op == opSwc);
      rdReq.con = (opE.op == opCfc);
    end
  end

  // Read value is held for the M stage bus drive
  always_ff @(posedge SYSCLK) begin
    if (rdReq.gen || rdReq.con) begin
      crdDataM <= rdData;
    end
  end

  //////////////////////////////
  // M stage bus
  //////////////////////////////

  assign cDriverM = (opM.op == opMfc) || (opM.op == opCfc) || (opM.op == opSwc);
  assign cmemOpM  = (opM.op == opLwc);   // Load data arrives on the up bus
  assign wrM      = (opM.op == opMtc) || (opM.op == opCtc) || (opM.op == opLwc);

  always_ff @(posedge SYSCLK) begin
    if (advance && wrM) begin
      wrDataW <= dbusCopIn;
    end
  end

  //////////////////////////////
  // W stage write
  //////////////////////////////

  always_comb begin
    wrReq      = '0;
    wrReq.addr = opW.addr;
    wrReq.data = wrDataW;
    if (advance) begin
      wrReq.gen = (opW.op == opMtc) || (opW.op == opLwc);
      wrReq.con = (opW.op == opCtc);
    end
  end

  // Condition to the branch logic
  always_ff @(posedge SYSCLK) begin
    if (rst) begin
      cpCondN <= 1'b1;
    end else if (advance) begin
      cpCondN <= condN;
    end
  end

  // A read held by a halt is issued again once the halt drops
  rdReissue: assert property (@(posedge SYSCLK) disable iff (rst)
    ((|halt) && !exception && (opE.op inside {opMfc, opCfc, opSwc})) |=>
      ((|halt) || rdReq.gen || rdReq.con));

  // A write held by a halt waits in W until every halt bit drops
  heldWrWaits: assert property (@(posedge SYSCLK) disable iff (rst)
    ((|halt) && (opW.op inside {opMtc, opCtc, opLwc})) |=>
      ((|halt) || wrReq.gen || wrReq.con));

endmodule

// File: hdl/copPkg.sv
package copPkg;

  //////////////////////////////
  // Basic types
  //////////////////////////////

  typedef logic [31:0] wordT;
  typedef logic [4:0]  regAddrT;

  // Field split of a coprocessor move or load/store word
  typedef struct packed {
    logic [5:0]  opcode;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  rd;
    logic [10:0] rest;
  } instFieldsT;

  //////////////////////////////
  // Encodings
  //////////////////////////////

  // Major opcodes with the coprocessor number in the low two bits
  localparam logic [5:0] COP0 = 6'b010000;
  localparam logic [5:0] COP1 = 6'b010001;
  localparam logic [5:0] COP2 = 6'b010010;
  localparam logic [5:0] COP3 = 6'b010011;
  localparam logic [5:0] LWC  = 6'b110000;   // LWCz is LWC plus z
  localparam logic [5:0] SWC  = 6'b111000;   // SWCz is SWC plus z

  // The rs field of a COPz word
  localparam logic [4:0] MF = 5'b00000;
  localparam logic [4:0] CF = 5'b00010;
  localparam logic [4:0] MT = 5'b00100;
  localparam logic [4:0] CT = 5'b00110;
  localparam logic [4:0] BC = 5'b01000;

  typedef enum logic [2:0] {
    opNone, opMfc, opCfc, opMtc, opCtc, opLwc, opSwc, opBc
  } copOpE;

  typedef struct packed {
    copOpE   op;
    regAddrT addr;
  } copOpT;

  //////////////////////////////
  // Pipeline and register ports
  //////////////////////////////

  typedef struct packed {
    logic pipeHalt;
    logic dcHaltM;   // Data cache halts
    logic dcHaltW;
    logic dwHaltW;   // Write buffer full
  } haltT;

  typedef struct packed {
    logic    gen;
    logic    con;
    regAddrT addr;
  } rdReqT;

  typedef struct packed {
    logic    gen;
    logic    con;
    regAddrT addr;
    wordT    data;
  } wrReqT;

endpackage

// File: hdl/copRegs.sv
module copRegs
  import copPkg::*;
(
  input  logic  SYSCLK,
  input  logic  rst,
  input  rdReqT rdReq,
  input  wrReqT wrReq,
  output wordT  rdData,
  output logic  condN
);

  localparam int NUM_REGS = 32;

  wordT genRegs [NUM_REGS];
  wordT conRegs [NUM_REGS];

  //////////////////////////////
  // Register banks
  //////////////////////////////

  always_ff @(posedge SYSCLK) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        genRegs[i] <= '0;
        conRegs[i] <= '0;
      end
    end else begin
      if (wrReq.gen) begin
        genRegs[wrReq.addr] <= wrReq.data;
      end
      if (wrReq.con) begin
        conRegs[wrReq.addr] <= wrReq.data;
      end
    end
  end

  //////////////////////////////
  // Read port
  //////////////////////////////

  // Same cycle answer so the interface can latch it at the end of E
  always_comb begin
    rdData = '0;
    if (rdReq.con) begin
      rdData = conRegs[rdReq.addr];
    end else if (rdReq.gen) begin
      rdData = genRegs[rdReq.addr];
    end
  end

  // Control register 0 bit 0 is the branch condition
  assign condN = ~conRegs[0][0];

endmodule

// File: hdl/copTop.sv
module copTop
  import copPkg::*;
#(
  parameter int COP_NUM = 2
) (
  input  logic SYSCLK,
  input  logic rst,
  input  wordT instIf,
  input  logic iStallIf,
  input  logic exception,
  input  haltT halt,
  input  wordT dbusUpIn,
  output wordT dbusUpOut,
  input  wordT dbusDownIn,
  output wordT dbusDownOut,
  output logic cpCondN
);

  rdReqT rdReq;
  wrReqT wrReq;
  wordT  rdData;
  logic  condN;

  copBus #(
    .COP_NUM(COP_NUM)
  ) bus (
    .SYSCLK     (SYSCLK),
    .rst        (rst),
    .instIf     (instIf),
    .iStallIf   (iStallIf),
    .exception  (exception),
    .halt       (halt),
    .dbusUpIn   (dbusUpIn),
    .dbusUpOut  (dbusUpOut),
    .dbusDownIn (dbusDownIn),
    .dbusDownOut(dbusDownOut),
    .cpCondN    (cpCondN),
    .rdReq      (rdReq),
    .wrReq      (wrReq),
    .rdData     (rdData),
    .condN      (condN)
  );

  copRegs regs (
    .SYSCLK(SYSCLK),
    .rst   (rst),
    .rdReq (rdReq),
    .wrReq (wrReq),
    .rdData(rdData),
    .condN (condN)
  );

endmodule

// File: list.f
hdl/copPkg.sv
hdl/copDecode.sv
hdl/copIf.sv
hdl/copBusSteer.sv
hdl/copBus.sv
hdl/copRegs.sv
hdl/copTop.sv
dv/copTb.sv
